// File: hdl/ifu_cfg.svh
`ifndef IFU_CFG_SVH
`define IFU_CFG_SVH

// width of a fetch address and of an instruction word.
`define IFU_XLEN 32

// the request queue only needs to cover the issue latency of the memory port.
`define IFU_REQ_DEPTH 2

// instruction queue between the memory port and decode.
`define IFU_INST_DEPTH 4

// first fetch address after reset.
`define IFU_RESET_PC 32'h8000_0000

`endif

// File: hdl/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

  `include "ifu_cfg.svh"

  // a fetch address.
  typedef logic [`IFU_XLEN-1:0] pc_t;

  // one fetched instruction together with the address it came from.
  typedef struct packed {
    pc_t                 pc;
    logic [`IFU_XLEN-1:0] inst;
  } fetch_pkt_t;

endpackage

`default_nettype wire

// File: hdl/fetch_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_fifo #(
  parameter int unsigned depth      = 2,
  parameter type         payload_t  = logic [31:0],
  parameter int unsigned addr_width = (depth > 1) ? $clog2(depth) : 1
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                flush,
  input  logic                push,
  input  logic                pop,
  input  payload_t            wdata,
  output payload_t            rdata,
  output logic                full,
  output logic                empty,
  output logic [addr_width:0] count
);

  payload_t              storage [depth];
  logic [addr_width-1:0] rd_ptr_q;
  logic [addr_width-1:0] rd_ptr_d;
  logic [addr_width-1:0] wr_ptr_q;
  logic [addr_width-1:0] wr_ptr_d;
  logic [addr_width:0]   count_q;
  logic [addr_width:0]   count_d;
  logic                  do_push;
  logic                  do_pop;

  assign full  = count_q == (addr_width + 1)'(depth);
  assign empty = count_q == '0;
  assign count = count_q;
  assign rdata = storage[rd_ptr_q];

  // full and empty guard the strobes, so callers may hold them.
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_comb begin
    rd_ptr_d = rd_ptr_q;
    wr_ptr_d = wr_ptr_q;
    count_d  = count_q;
    if (do_pop) begin
      rd_ptr_d = (rd_ptr_q == addr_width'(depth - 1)) ? '0 : rd_ptr_q + 1'b1;
    end
    if (do_push) begin
      wr_ptr_d = (wr_ptr_q == addr_width'(depth - 1)) ? '0 : wr_ptr_q + 1'b1;
    end
    // a simultaneous push and pop leaves the occupancy unchanged.
    if (do_push && !do_pop) begin
      count_d = count_q + 1'b1;
    end else if (do_pop && !do_push) begin
      count_d = count_q - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      rd_ptr_q <= rd_ptr_d;
      wr_ptr_q <= wr_ptr_d;
      count_q  <= count_d;
    end
  end

  always_ff @(posedge clock) begin
    if (do_push && !flush) begin
      storage[wr_ptr_q] <= wdata;
    end
  end

endmodule

`default_nettype wire

// File: hdl/fetch_pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_cfg.svh"

module fetch_pc_gen (
  input  logic          clock,
  input  logic          reset,
  input  logic          redirect_valid,
  input  ifu_pkg::pc_t  redirect_pc,
  input  logic          req_full,
  output logic          req_push,
  output ifu_pkg::pc_t  req_pc
);

  ifu_pkg::pc_t next_pc;

  // the queue is flushed by the same redirect, so nothing is pushed in that cycle.
  assign req_push = !req_full && !redirect_valid;
  assign req_pc   = next_pc;

  always_ff @(posedge clock) begin
    if (reset) begin
      next_pc <= `IFU_RESET_PC;
    end else if (redirect_valid) begin
      next_pc <= redirect_pc;
    end else if (req_push) begin
      next_pc <= next_pc + ifu_pkg::pc_t'(4);
    end
  end

endmodule

`default_nettype wire

// File: hdl/imem_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_cfg.svh"

module imem_port (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  redirect_valid,
  input  logic                  req_empty,
  input  ifu_pkg::pc_t          req_head,
  output logic                  req_pop,
  output logic                  imem_req,
  output ifu_pkg::pc_t          imem_addr,
  input  logic                  imem_rvalid,
  input  logic [`IFU_XLEN-1:0]  imem_rdata,
  input  logic                  pkt_full,
  output logic                  pkt_push,
  output ifu_pkg::fetch_pkt_t   pkt_data
);

  logic         busy;
  logic         drop;
  logic         issue;
  ifu_pkg::pc_t req_pc_q;

  // only one request may be outstanding. Requiring room in the instruction
  // queue at issue time guarantees the response can always be written.
  assign issue = !busy && !req_empty && !pkt_full && !redirect_valid;

  assign req_pop   = issue;
  assign imem_req  = issue;
  assign imem_addr = req_head;

  // a response that belongs to a pc before the last redirect is thrown away.
  assign pkt_push      = imem_rvalid && busy && !drop && !redirect_valid;
  assign pkt_data.pc   = req_pc_q;
  assign pkt_data.inst = imem_rdata;

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (issue) begin
      busy <= 1'b1;
    end else if (imem_rvalid) begin
      busy <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      drop <= 1'b0;
    end else if (imem_rvalid) begin
      drop <= 1'b0;
    end else if (redirect_valid && busy) begin
      drop <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (issue) begin
      req_pc_q <= req_head;
    end
  end

endmodule

`default_nettype wire

// File: hdl/ifu_frontend.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_frontend (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 redirect_valid,
  input  ifu_pkg::pc_t         redirect_pc,
  output logic                 imem_req,
  output ifu_pkg::pc_t         imem_addr,
  input  logic                 imem_rvalid,
  input  logic [`IFU_XLEN-1:0] imem_rdata,
  output logic                 inst_valid,
  output ifu_pkg::pc_t         inst_pc,
  output logic [`IFU_XLEN-1:0] inst_word,
  input  logic                 inst_take
);

  logic                req_push;
  ifu_pkg::pc_t        req_pc;
  logic                req_full;
  logic                req_pop;
  logic                req_empty;
  ifu_pkg::pc_t        req_head;
  logic                pkt_push;
  ifu_pkg::fetch_pkt_t pkt_data;
  logic                pkt_full;
  logic                inst_empty;
  ifu_pkg::fetch_pkt_t inst_head;

  fetch_pc_gen u_pc_gen (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .req_full       (req_full),
    .req_push       (req_push),
    .req_pc         (req_pc)
  );

  fetch_fifo #(
    .depth     (`IFU_REQ_DEPTH),
    .payload_t (ifu_pkg::pc_t)
  ) u_req_q (
    .clock (clock),
    .reset (reset),
    .flush (redirect_valid),
    .push  (req_push),
    .pop   (req_pop),
    .wdata (req_pc),
    .rdata (req_head),
    .full  (req_full),
    .empty (req_empty),
    .count ()
  );

  imem_port u_imem_port (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .req_empty      (req_empty),
    .req_head       (req_head),
    .req_pop        (req_pop),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_rvalid    (imem_rvalid),
    .imem_rdata     (imem_rdata),
    .pkt_full       (pkt_full),
    .pkt_push       (pkt_push),
    .pkt_data       (pkt_data)
  );

  fetch_fifo #(
    .depth     (`IFU_INST_DEPTH),
    .payload_t (ifu_pkg::fetch_pkt_t)
  ) u_inst_q (
    .clock (clock),
    .reset (reset),
    .flush (redirect_valid),
    .push  (pkt_push),
    .pop   (inst_take),
    .wdata (pkt_data),
    .rdata (inst_head),
    .full  (pkt_full),
    .empty (inst_empty),
    .count ()
  );

  // the head of the instruction queue is presented straight to decode.
  assign inst_valid = !inst_empty;
  assign inst_pc    = inst_head.pc;
  assign inst_word  = inst_head.inst;

endmodule

`default_nettype wire

// File: verification/ifu_frontend_checker.sv
`timescale 1ns/10ps
`default_nettype none

module ifu_frontend_checker (
  input logic clock,
  input logic reset,
  input logic redirect_valid,
  input logic imem_req,
  input logic imem_rvalid,
  input logic inst_valid
);

  logic        outstanding;
  int unsigned failures;

  initial begin
    failures = 0;
  end

  // set by a request and cleared by its response, stale or not.
  always_ff @(posedge clock) begin
    if (reset) begin
      outstanding <= 1'b0;
    end else if (imem_req) begin
      outstanding <= 1'b1;
    end else if (imem_rvalid) begin
      outstanding <= 1'b0;
    end
  end

  a_one_outstanding : assert property (
    @(posedge clock) disable iff (reset) imem_req |-> !outstanding
  ) else begin
    failures = failures + 1;
    $error("imem_req issued while a request is still outstanding");
  end

  a_quiet_after_reset : assert property (
    @(posedge clock) $fell(reset) |-> (!imem_req && !inst_valid)
  ) else begin
    failures = failures + 1;
    $error("imem_req or inst_valid high in the first cycle after reset");
  end

  a_no_req_on_redirect : assert property (
    @(posedge clock) disable iff (reset) redirect_valid |-> !imem_req
  ) else begin
    failures = failures + 1;
    $error("imem_req issued in the same cycle as a redirect");
  end

endmodule

bind ifu_frontend ifu_frontend_checker u_checker (
  .clock          (clock),
  .reset          (reset),
  .redirect_valid (redirect_valid),
  .imem_req       (imem_req),
  .imem_rvalid    (imem_rvalid),
  .inst_valid     (inst_valid)
);

`default_nettype wire

// File: verification/ifu_frontend_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ifu_cfg.svh"

module ifu_frontend_monitor (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 redirect_valid,
  input  logic                 inst_valid,
  input  logic                 inst_take,
  input  ifu_pkg::pc_t         inst_pc,
  input  logic [`IFU_XLEN-1:0] inst_word,
  output int                   taken_count,
  output int                   mismatch_count,
  output int                   error_count
);

  logic [8*16-1:0]      exp_name_q [$];
  ifu_pkg::pc_t         exp_pc_q [$];
  logic [`IFU_XLEN-1:0] exp_word_q [$];
  logic                 redirect_q;

  initial begin
    taken_count    = 0;
    mismatch_count = 0;
    error_count    = 0;
  end

  task automatic add_expected(input logic [8*16-1:0] name, input ifu_pkg::pc_t pc,
                              input logic [`IFU_XLEN-1:0] word);
    exp_name_q.push_back(name);
    exp_pc_q.push_back(pc);
    exp_word_q.push_back(word);
  endtask

  function automatic int pending_count();
    return exp_pc_q.size();
  endfunction

  always @(posedge clock) begin
    logic [8*16-1:0]      name;
    ifu_pkg::pc_t         exp_pc;
    logic [`IFU_XLEN-1:0] exp_word;
    if (reset) begin
      redirect_q <= 1'b0;
    end else begin
      // a redirect flushes the queue, so decode sees nothing in the next cycle.
      if (redirect_q && inst_valid) begin
        error_count = error_count + 1;
        $display("ERROR: inst_valid stayed high in the cycle after a redirect");
      end
      if (inst_valid && inst_take && !redirect_valid) begin
        if (exp_pc_q.size() == 0) begin
          error_count = error_count + 1;
          $display("ERROR: packet at pc %h taken after the expected stream ended", inst_pc);
        end else begin
          name     = exp_name_q.pop_front();
          exp_pc   = exp_pc_q.pop_front();
          exp_word = exp_word_q.pop_front();
          if (inst_pc !== exp_pc) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH %0s packet %0d pc: expected %h, actual %h",
                     name, taken_count, exp_pc, inst_pc);
          end
          if (inst_word !== exp_word) begin
            mismatch_count = mismatch_count + 1;
            $display("MISMATCH %0s packet %0d inst: expected %h, actual %h",
                     name, taken_count, exp_word, inst_word);
          end
          taken_count = taken_count + 1;
        end
      end
      redirect_q <= redirect_valid;
    end
  end

endmodule

module ifu_frontend_tb;

  localparam int reset_cycles      = 16;
  localparam int cycles_per_packet = 40;
  localparam int max_entries       = 64;

  logic                 clock;
  logic                 reset;
  logic                 redirect_valid;
  ifu_pkg::pc_t         redirect_pc;
  logic                 imem_req;
  ifu_pkg::pc_t         imem_addr;
  logic                 imem_rvalid;
  logic [`IFU_XLEN-1:0] imem_rdata;
  logic                 inst_valid;
  ifu_pkg::pc_t         inst_pc;
  logic [`IFU_XLEN-1:0] inst_word;
  logic                 inst_take;

  integer seed = 32'h132;

  ifu_pkg::pc_t         img_addr [max_entries];
  logic [`IFU_XLEN-1:0] img_word [max_entries];
  logic [7:0]           ev_kind [max_entries];
  int                   ev_at [max_entries];
  ifu_pkg::pc_t         ev_pc [max_entries];
  int                   ev_cycles [max_entries];
  int                   ev_mode [max_entries];
  int                   n_img;
  int                   n_events;
  int                   n_expected;
  int                   timeout_cycles;
  int                   local_errors;
  logic                 loaded;

  logic                 req_seen;
  ifu_pkg::pc_t         req_addr;
  logic                 in_flight;
  logic                 mem_pending;
  ifu_pkg::pc_t         mem_addr;
  int                   mem_delay;

  int                   taken_count;
  int                   mismatch_count;
  int                   error_count;

  initial begin
    clock = 1'b0;
  end

  always #4 clock = ~clock;

  ifu_frontend u_dut (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .imem_req       (imem_req),
    .imem_addr      (imem_addr),
    .imem_rvalid    (imem_rvalid),
    .imem_rdata     (imem_rdata),
    .inst_valid     (inst_valid),
    .inst_pc        (inst_pc),
    .inst_word      (inst_word),
    .inst_take      (inst_take)
  );

  ifu_frontend_monitor u_mon (
    .clock          (clock),
    .reset          (reset),
    .redirect_valid (redirect_valid),
    .inst_valid     (inst_valid),
    .inst_take      (inst_take),
    .inst_pc        (inst_pc),
    .inst_word      (inst_word),
    .taken_count    (taken_count),
    .mismatch_count (mismatch_count),
    .error_count    (error_count)
  );

  // addresses outside the image read back a pattern built from the address.
  function automatic logic [`IFU_XLEN-1:0] read_image(input ifu_pkg::pc_t addr);
    for (int i = 0; i < n_img; i++) begin
      if (img_addr[i] == addr) begin
        return img_word[i];
      end
    end
    return addr ^ 32'h5a5a_a5a5;
  endfunction

  task automatic load_golden();
    int                   fd;
    int                   code;
    int                   n;
    int                   m;
    int                   mode;
    logic [8*16-1:0]      tag;
    logic [8*16-1:0]      test_name;
    logic [8*128-1:0]     rest;
    ifu_pkg::pc_t         a;
    logic [`IFU_XLEN-1:0] w;
    n_img      = 0;
    n_events   = 0;
    n_expected = 0;
    test_name  = "none";
    fd = $fopen("verification/ifu_frontend_golden.txt", "r");
    if (fd == 0) begin
      $display("ERROR: could not open the golden file");
      local_errors = local_errors + 1;
      return;
    end
    code = 1;
    while (code == 1) begin
      tag  = '0;
      code = $fscanf(fd, "%s", tag);
      if (code == 1) begin
        if (tag == "#") begin
          n = $fgets(rest, fd);
        end else if (tag == "T") begin
          n = $fscanf(fd, "%s", test_name);
        end else if (tag == "M") begin
          n = $fscanf(fd, "%h %h", a, w);
          img_addr[n_img] = a;
          img_word[n_img] = w;
          n_img = n_img + 1;
        end else if (tag == "E") begin
          n = $fscanf(fd, "%h %h", a, w);
          u_mon.add_expected(test_name, a, w);
          n_expected = n_expected + 1;
        end else if (tag == "S" || tag == "R") begin
          a    = '0;
          mode = 0;
          if (tag == "S") begin
            n = $fscanf(fd, "%d %d", ev_at[n_events], m);
          end else begin
            n = $fscanf(fd, "%d %h %d %d", ev_at[n_events], a, m, mode);
          end
          ev_kind[n_events]   = tag[7:0];
          ev_pc[n_events]     = a;
          ev_cycles[n_events] = m;
          ev_mode[n_events]   = mode;
          n_events = n_events + 1;
        end else begin
          $display("ERROR: unknown record in the golden file");
          local_errors = local_errors + 1;
        end
      end
    end
    $fclose(fd);
  endtask

  // take is held low for the stall, then a redirect waits for the wanted memory state.
  task automatic run_event(input int idx);
    inst_take = 1'b0;
    repeat (ev_cycles[idx]) @(negedge clock);
    if (ev_kind[idx] == "R") begin
      while (in_flight != (ev_mode[idx] == 1)) begin
        @(negedge clock);
      end
      redirect_pc    = ev_pc[idx];
      redirect_valid = 1'b1;
      @(negedge clock);
      redirect_valid = 1'b0;
    end
  endtask

  task automatic end_run();
    int total;
    if (u_mon.pending_count() != 0) begin
      $display("ERROR: %0d expected packets were never taken", u_mon.pending_count());
      local_errors = local_errors + 1;
    end
    total = mismatch_count + error_count + local_errors + u_dut.u_checker.failures;
    $display("errors: %0d mismatch, %0d monitor, %0d run, %0d assertion",
             mismatch_count, error_count, local_errors, u_dut.u_checker.failures);
    if (total == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  always @(posedge clock) begin
    req_seen <= imem_req && !reset;
    req_addr <= imem_addr;
    if (reset) begin
      in_flight <= 1'b0;
    end else if (imem_req) begin
      in_flight <= 1'b1;
    end else if (imem_rvalid) begin
      in_flight <= 1'b0;
    end
  end

  // memory model with a random latency of 1 to 6 cycles per request.
  always @(negedge clock) begin
    if (reset) begin
      mem_pending = 1'b0;
      imem_rvalid = 1'b0;
    end else begin
      imem_rvalid = 1'b0;
      if (req_seen) begin
        mem_pending = 1'b1;
        mem_addr    = req_addr;
        mem_delay   = 1 + ($unsigned($random(seed)) % 6);
      end
      if (mem_pending) begin
        mem_delay = mem_delay - 1;
        if (mem_delay == 0) begin
          imem_rvalid = 1'b1;
          imem_rdata  = read_image(mem_addr);
          mem_pending = 1'b0;
        end
      end
    end
  end

  initial begin
    int ev_idx;
    reset          = 1'b1;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    imem_rvalid    = 1'b0;
    imem_rdata     = '0;
    inst_take      = 1'b0;
    local_errors   = 0;
    loaded         = 1'b0;
    ev_idx         = 0;
    load_golden();
    timeout_cycles = reset_cycles + cycles_per_packet * n_expected;
    loaded = 1'b1;
    repeat (reset_cycles) @(negedge clock);
    reset = 1'b0;
    while (taken_count < n_expected) begin
      if (ev_idx < n_events && taken_count == ev_at[ev_idx]) begin
        run_event(ev_idx);
        ev_idx = ev_idx + 1;
      end else begin
        inst_take = ($random(seed) & 3) != 0;
        @(negedge clock);
      end
    end
    inst_take = 1'b0;
    repeat (8) @(negedge clock);
    end_run();
  end

  initial begin
    wait (loaded);
    repeat (timeout_cycles) @(posedge clock);
    $display("ERROR: the run did not finish within %0d cycles", timeout_cycles);
    local_errors = local_errors + 1;
    end_run();
  end

endmodule

`default_nettype wire

// File: verification/ifu_frontend_golden.txt
# records: M addr word = memory image, T name = test label, E pc word = expected packet
# S n cycles = hold take low after n packets, R n pc stall mode = redirect after n packets
M 80000000 00100093
M 80000004 00200113
M 80000008 00300193
M 8000000c 00400213
M 80000010 00500293
M 80000014 00600313
M 80000018 00700393
M 8000001c 00800413
M 80000100 06400493
M 80000104 06500513
M 80000108 06600593
M 8000010c 06700613
M 80000200 0c800693
M 80000204 0c900713
M 80000208 0ca00793
M 8000020c 0cb00813
M 80000040 12c00893
M 80000044 12d00913
M 80000048 12e00993
M 8000004c 12f00a13
M 80000050 13000a93
M 80000054 13100b13
M 80000058 13200b93
M 8000005c 13300c13
M 80000060 13400c93
M 80000064 13500d13
M 80000068 13600d93
M 8000006c 13700e13
S 4 30
R 8 80000100 0 0
R 12 80000200 0 1
R 16 80000040 30 0
T sequential
E 80000000 00100093
E 80000004 00200113
E 80000008 00300193
E 8000000c 00400213
T back_pressure
E 80000010 00500293
E 80000014 00600313
E 80000018 00700393
E 8000001c 00800413
T redirect_idle
E 80000100 06400493
E 80000104 06500513
E 80000108 06600593
E 8000010c 06700613
T redirect_busy
E 80000200 0c800693
E 80000204 0c900713
E 80000208 0ca00793
E 8000020c 0cb00813
T redirect_full
E 80000040 12c00893
E 80000044 12d00913
E 80000048 12e00993
E 8000004c 12f00a13
E 80000050 13000a93
E 80000054 13100b13
T latency
E 80000058 13200b93
E 8000005c 13300c13
E 80000060 13400c93
E 80000064 13500d13
E 80000068 13600d93
E 8000006c 13700e13

// File: files.f
+incdir+hdl
hdl/ifu_pkg.sv
hdl/fetch_fifo.sv
hdl/fetch_pc_gen.sv
hdl/imem_port.sv
hdl/ifu_frontend.sv
verification/ifu_frontend_checker.sv
verification/ifu_frontend_tb.sv

// File: Bender.yml
package:
  name: ifu_frontend

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ifu_pkg.sv
      - hdl/fetch_fifo.sv
      - hdl/fetch_pc_gen.sv
      - hdl/imem_port.sv
      - hdl/ifu_frontend.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verification/ifu_frontend_checker.sv
      - verification/ifu_frontend_tb.sv
